//--- logic/uart_pkg.sv
package uart_pkg;

  localparam int wb_width = 32;

  // word addresses on the Wishbone port.
  typedef enum logic [1:0] {
    reg_data   = 2'd0,
    reg_status = 2'd1,
    reg_ctrl   = 2'd2
  } reg_addr_e;

  // CTRL register layout, parity enable sits at bit 16.
  typedef struct packed {
    logic        parity_enable;
    logic [15:0] divisor;       // clk cycles per tick, minus one.
  } uart_cfg_t;

  // one received frame.
  typedef struct packed {
    logic [7:0] data;           // zero filled above DATA_BITS.
    logic       parity_err;
    logic       frame_err;
  } rx_result_t;

endpackage

//--- logic/baud_gen.sv
`timescale 1ns/10ps

module baud_gen (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] divisor,
  output logic        tick
);

  logic [15:0] count;

  // a new divisor is picked up only when the counter reloads.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= divisor;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
  parameter int DATA_BITS  = 8,
  parameter int OVS_FACTOR = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 rx_pin,
  input  logic                 parity_enable,
  output uart_pkg::rx_result_t rx_result,
  output logic                 rx_done
);

  localparam int os_w  = $clog2(OVS_FACTOR);
  localparam int idx_w = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;
  localparam logic [os_w-1:0] mid_tick = os_w'(OVS_FACTOR / 2 - 1);
  localparam logic [os_w-1:0] last_tick = os_w'(OVS_FACTOR - 1);
  localparam logic [idx_w-1:0] last_bit = idx_w'(DATA_BITS - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop,
    st_done
  } rx_state_e;

  rx_state_e state;
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic [os_w-1:0] os_count;
  logic [idx_w-1:0] bit_index;
  logic [DATA_BITS-1:0] rx_shift;
  logic parity_bad;
  logic counting;
  logic bit_sample;

  // counter restarts at the start bit mid-sample, so later samples land mid-bit.
  assign counting   = (state == st_data) || (state == st_parity) || (state == st_stop);
  assign bit_sample = tick && (os_count == last_tick);
  assign rx_done    = (state == st_done);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= st_idle;
      rx_prev    <= 1'b1;
      os_count   <= '0;
      bit_index  <= '0;
      parity_bad <= 1'b0;
    end else begin
      if (tick) rx_prev <= rx_sync;
      if (counting && tick) os_count <= (os_count == last_tick) ? '0 : os_count + 1'b1;
      case (state)
        st_idle: begin
          if (tick && rx_prev && !rx_sync) begin  // falling edge.
            state    <= st_start;
            os_count <= '0;
          end
        end
        st_start: begin
          if (tick) begin
            if (os_count == mid_tick) begin
              os_count   <= '0;
              bit_index  <= '0;
              parity_bad <= 1'b0;
              state      <= rx_sync ? st_idle : st_data;  // high here is a glitch.
            end else begin
              os_count <= os_count + 1'b1;
            end
          end
        end
        st_data: begin
          if (bit_sample) begin
            bit_index <= bit_index + 1'b1;
            if (bit_index == last_bit) state <= parity_enable ? st_parity : st_stop;
          end
        end
        st_parity: begin
          if (bit_sample) begin
            parity_bad <= ~(^rx_shift ^ rx_sync);  // even count of ones.
            state      <= st_stop;
          end
        end
        st_stop: begin
          if (bit_sample) state <= st_done;
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // data arrives LSB first.
  always_ff @(posedge clk) begin
    if (state == st_data && bit_sample) rx_shift <= {rx_sync, rx_shift[DATA_BITS-1:1]};
    if (state == st_stop && bit_sample) begin
      rx_result.data       <= 8'(rx_shift);
      rx_result.parity_err <= parity_bad;
      rx_result.frame_err  <= ~rx_sync;
    end
  end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
  parameter int DATA_BITS  = 8,
  parameter int OVS_FACTOR = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 parity_enable,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_data,
  output logic                 tx_pin,
  output logic                 tx_busy
);

  localparam int frame_w = DATA_BITS + 3;
  localparam int cnt_w   = $clog2(frame_w + 1);
  localparam int os_w    = $clog2(OVS_FACTOR);
  localparam logic [os_w-1:0] last_tick = os_w'(OVS_FACTOR - 1);

  logic [frame_w-1:0] shifter;
  logic [cnt_w-1:0] bits_left;
  logic [os_w-1:0] os_count;
  logic load;
  logic shift_now;
  logic parity_bit;

  assign load       = tx_start && !tx_busy;
  assign parity_bit = ~^tx_data;  // odd parity.
  assign shift_now  = tx_busy && tick && (os_count == '0) && (bits_left != '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tx_busy   <= 1'b0;
      tx_pin    <= 1'b1;
      os_count  <= '0;
      bits_left <= '0;
    end else if (load) begin
      tx_busy   <= 1'b1;
      os_count  <= '0;
      bits_left <= parity_enable ? cnt_w'(DATA_BITS + 3) : cnt_w'(DATA_BITS + 2);
    end else if (tx_busy && tick) begin
      os_count <= (os_count == last_tick) ? '0 : os_count + 1'b1;
      if (shift_now) begin
        tx_pin    <= shifter[0];
        bits_left <= bits_left - 1'b1;
      end else if (bits_left == '0 && os_count == last_tick) begin
        tx_busy <= 1'b0;  // end of the stop bit, line stays high.
      end
    end
  end

  // without parity the slot after the data is simply the stop bit.
  always_ff @(posedge clk) begin
    if (load) shifter <= {1'b1, parity_enable ? parity_bit : 1'b1, tx_data, 1'b0};
    else if (shift_now) shifter <= {1'b1, shifter[frame_w-1:1]};
  end

endmodule

//--- logic/uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
  parameter int DATA_BITS = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  uart_pkg::reg_addr_e           wb_adr,
  input  logic [uart_pkg::wb_width-1:0] wb_dat_w,
  output logic [uart_pkg::wb_width-1:0] wb_dat_r,
  output logic                          wb_ack,
  input  uart_pkg::rx_result_t          rx_result,
  input  logic                          rx_done,
  input  logic                          tx_busy,
  output uart_pkg::uart_cfg_t           cfg,
  output logic                          tx_start,
  output logic [DATA_BITS-1:0]          tx_data
);

  import uart_pkg::*;

  rx_result_t rx_latch;
  logic rx_valid;
  logic overrun;
  logic access;
  logic wr_data;
  logic wr_ctrl;
  logic rd_data;
  logic rd_status;

  assign access    = wb_cyc && wb_stb && wb_ack;  // transfer completes on the ack edge.
  assign wr_data   = access && wb_we && (wb_adr == reg_data);
  assign wr_ctrl   = access && wb_we && (wb_adr == reg_ctrl);
  assign rd_data   = access && !wb_we && (wb_adr == reg_data);
  assign rd_status = access && !wb_we && (wb_adr == reg_status);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) wb_ack <= 1'b0;
    else wb_ack <= wb_cyc && wb_stb && !wb_ack;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg      <= '0;
      tx_start <= 1'b0;
      rx_latch <= '0;
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      tx_start <= wr_data && !tx_busy;  // busy transmitter drops the write.
      if (wr_ctrl) cfg <= uart_cfg_t'(wb_dat_w[$bits(uart_cfg_t)-1:0]);
      if (rd_data) rx_valid <= 1'b0;
      if (rd_status) overrun <= 1'b0;
      // a new frame wins over a clear in the same cycle.
      if (rx_done) begin
        rx_latch <= rx_result;
        rx_valid <= 1'b1;
        if (rx_valid && !rd_data) overrun <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_data && !tx_busy) tx_data <= wb_dat_w[DATA_BITS-1:0];
  end

  always_comb begin
    case (wb_adr)
      reg_data:   wb_dat_r = wb_width'(rx_latch.data);
      reg_status: wb_dat_r = wb_width'({overrun, rx_latch.frame_err, rx_latch.parity_err,
                                        tx_busy, rx_valid});
      reg_ctrl:   wb_dat_r = wb_width'(cfg);
      default:    wb_dat_r = '0;
    endcase
  end

endmodule

//--- logic/uart_top.sv
`timescale 1ns/10ps

module uart_top #(
  parameter int DATA_BITS  = 8,
  parameter int OVS_FACTOR = 16
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  uart_pkg::reg_addr_e           wb_adr,
  input  logic [uart_pkg::wb_width-1:0] wb_dat_w,
  output logic [uart_pkg::wb_width-1:0] wb_dat_r,
  output logic                          wb_ack,
  input  logic                          rx_pin,
  output logic                          tx_pin
);

  import uart_pkg::*;

  uart_cfg_t cfg;
  rx_result_t rx_result;
  logic tick;
  logic rx_done;
  logic tx_start;
  logic tx_busy;
  logic [DATA_BITS-1:0] tx_data;

  uart_regs #(
    .DATA_BITS(DATA_BITS)
  ) regs_i (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rx_result(rx_result),
    .rx_done  (rx_done),
    .tx_busy  (tx_busy),
    .cfg      (cfg),
    .tx_start (tx_start),
    .tx_data  (tx_data)
  );

  // one tick source paces both directions.
  baud_gen baud_i (
    .clk    (clk),
    .reset  (reset),
    .divisor(cfg.divisor),
    .tick   (tick)
  );

  uart_rx #(
    .DATA_BITS (DATA_BITS),
    .OVS_FACTOR(OVS_FACTOR)
  ) rx_i (
    .clk          (clk),
    .reset        (reset),
    .tick         (tick),
    .rx_pin       (rx_pin),
    .parity_enable(cfg.parity_enable),
    .rx_result    (rx_result),
    .rx_done      (rx_done)
  );

  uart_tx #(
    .DATA_BITS (DATA_BITS),
    .OVS_FACTOR(OVS_FACTOR)
  ) tx_i (
    .clk          (clk),
    .reset        (reset),
    .tick         (tick),
    .parity_enable(cfg.parity_enable),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .tx_pin       (tx_pin),
    .tx_busy      (tx_busy)
  );

endmodule

//--- sim/uart_props.sv
`timescale 1ns/10ps

module uart_props (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic tx_busy,
  input logic tx_pin
);

  int failures = 0;

  ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
      failures++;
      $error("wb_ack stayed high for two cycles");
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |-> wb_cyc && wb_stb)
    else begin
      failures++;
      $error("wb_ack raised outside a bus cycle");
    end

  // the line idles high between frames.
  line_idle: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx_pin)
    else begin
      failures++;
      $error("tx_pin low while the transmitter is idle");
    end

endmodule

//--- sim/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;

  import uart_pkg::*;

  localparam int data_bits   = 8;
  localparam int ovs_factor  = 16;
  localparam int clk_period  = 4;
  localparam int max_div     = 7;
  localparam int tx_frames   = 8;
  localparam int loop_frames = 8;
  localparam int frame_count = tx_frames + loop_frames + 6;
  // 12 bit times per frame plus one full reload of a 16 bit divisor.
  localparam longint watchdog_ns =
    2 * clk_period * (longint'(frame_count) * 12 * ovs_factor * (max_div + 1) + 65536);

  logic clk;
  logic reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  reg_addr_e wb_adr;
  logic [wb_width-1:0] wb_dat_w;
  logic [wb_width-1:0] wb_dat_r;
  logic wb_ack;
  logic rx_pin;
  logic tx_pin;
  logic rx_model;  // line driven by the serial model.
  logic loopback;
  logic [15:0] cur_div;
  logic [15:0] div_bound;  // largest divisor the tick counter may still hold.
  logic cur_parity;
  int error_count;

  assign rx_pin = loopback ? tx_pin : rx_model;

  uart_top #(
    .DATA_BITS (data_bits),
    .OVS_FACTOR(ovs_factor)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .rx_pin  (rx_pin),
    .tx_pin  (tx_pin)
  );

  bind uart_top uart_props props_i (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .tx_busy(tx_busy),
    .tx_pin (tx_pin)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired at %0t with %0d errors, run stopped", $time, error_count);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int bit_clocks();
    return ovs_factor * (int'(cur_div) + 1);
  endfunction

  // set when the data holds an even number of ones, so the total comes out odd.
  function automatic logic odd_parity_bit(input logic [7:0] data);
    return ($countones(data) % 2) == 0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one classic cycle with cyc and stb held until ack.
  task automatic bus_access(input logic we, input reg_addr_e adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do @(negedge clk); while (!wb_ack);
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic configure(input logic [15:0] div, input logic parity);
    logic [31:0] unused;
    bus_access(1'b1, reg_ctrl, 32'({parity, div}), unused);
    repeat (int'(div_bound) + 2) @(posedge clk);  // old count must run out first.
    cur_div    = div;
    cur_parity = parity;
    div_bound  = div;
  endtask

  task automatic wait_tx_idle();
    logic [31:0] status;
    do bus_access(1'b0, reg_status, '0, status); while (status[1]);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip_parity,
                            input logic stop_bit);
    logic [10:0] bits;
    int nbits;
    if (cur_parity) begin
      bits  = {stop_bit, odd_parity_bit(data) ^ flip_parity, data, 1'b0};
      nbits = 11;
    end else begin
      bits  = {1'b1, stop_bit, data, 1'b0};
      nbits = 10;
    end
    @(posedge clk);
    repeat (nbits) begin
      rx_model <= bits[0];
      bits = bits >> 1;
      repeat (bit_clocks()) @(posedge clk);
    end
    rx_model <= 1'b1;
    repeat (bit_clocks()) @(posedge clk);
  endtask

  // samples each bit in the middle, counted from the falling start edge.
  task automatic decode_tx(input logic [7:0] exp_data);
    logic [7:0] data;
    do @(negedge clk); while (tx_pin);
    repeat (bit_clocks() / 2) @(negedge clk);
    check_value("tx start bit", 32'(tx_pin), 32'd0);
    repeat (data_bits) begin
      repeat (bit_clocks()) @(negedge clk);
      data = {tx_pin, data[7:1]};
    end
    check_value("tx data", 32'(data), 32'(exp_data));
    if (cur_parity) begin
      repeat (bit_clocks()) @(negedge clk);
      check_value("tx parity bit", 32'(tx_pin), 32'(odd_parity_bit(exp_data)));
    end
    repeat (bit_clocks()) @(negedge clk);
    check_value("tx stop bit", 32'(tx_pin), 32'd1);
  endtask

  task automatic receive_and_check(input logic [7:0] exp_data, input logic [4:0] exp_flags);
    logic [31:0] status;
    logic [31:0] value;
    do bus_access(1'b0, reg_status, '0, status); while (!status[0]);
    check_value("status", status & 32'h1d, {27'b0, exp_flags});  // tx_busy masked.
    bus_access(1'b0, reg_data, '0, value);
    check_value("rx data", value, {24'b0, exp_data});
    bus_access(1'b0, reg_status, '0, status);
    check_value("rx_valid after data read", 32'(status[0]), 32'd0);
  endtask

  initial begin
    logic [31:0] value;
    logic [15:0] div;
    logic [7:0] tx_byte;
    logic [7:0] second_byte;
    logic parity;
    void'($urandom(81390));
    error_count = 0;
    reset       = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = reg_data;
    wb_dat_w    = '0;
    rx_model    = 1'b1;
    loopback    = 1'b0;
    cur_div     = '0;
    div_bound   = '0;
    cur_parity  = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    bus_access(1'b0, reg_status, '0, value);
    check_value("status after reset", value, 32'd0);
    repeat (8) begin
      div    = 16'($urandom);
      parity = 1'($urandom);
      bus_access(1'b1, reg_ctrl, 32'({parity, div}), value);
      bus_access(1'b0, reg_ctrl, '0, value);
      check_value("ctrl", value, 32'({parity, div}));
      if (div > div_bound) div_bound = div;
    end

    repeat (tx_frames) begin
      wait_tx_idle();
      configure(16'($urandom_range(max_div, 0)), 1'($urandom));
      tx_byte = 8'($urandom);
      bus_access(1'b1, reg_data, 32'(tx_byte), value);
      decode_tx(tx_byte);
    end

    @(posedge clk);
    loopback <= 1'b1;
    repeat (loop_frames) begin
      wait_tx_idle();
      configure(16'($urandom_range(max_div, 0)), 1'($urandom));
      tx_byte = 8'($urandom);
      bus_access(1'b1, reg_data, 32'(tx_byte), value);
      receive_and_check(tx_byte, 5'b00001);
    end
    wait_tx_idle();
    loopback <= 1'b0;

    // bad parity, then a low stop bit.
    configure(16'($urandom_range(max_div, 0)), 1'b1);
    tx_byte = 8'($urandom);
    send_frame(tx_byte, 1'b1, 1'b1);
    receive_and_check(tx_byte, 5'b00101);
    tx_byte = 8'($urandom);
    send_frame(tx_byte, 1'b0, 1'b0);
    receive_and_check(tx_byte, 5'b01001);

    tx_byte     = 8'($urandom);
    second_byte = 8'($urandom);
    send_frame(tx_byte, 1'b0, 1'b1);
    send_frame(second_byte, 1'b0, 1'b1);
    bus_access(1'b0, reg_status, '0, value);
    check_value("status with overrun", value & 32'h1d, 32'h11);
    bus_access(1'b0, reg_status, '0, value);
    check_value("overrun after status read", 32'(value[4]), 32'd0);
    receive_and_check(second_byte, 5'b00001);

    @(posedge clk);
    rx_model <= 1'b0;
    repeat (bit_clocks() / 4) @(posedge clk);
    rx_model <= 1'b1;
    repeat (11 * bit_clocks()) @(posedge clk);
    bus_access(1'b0, reg_status, '0, value);
    check_value("rx_valid after short start pulse", 32'(value[0]), 32'd0);

    error_count += dut_i.props_i.failures;
    $display("%0d errors", error_count);
    if (error_count == 0) $display("TEST OK");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

//--- uart_top.f
logic/uart_pkg.sv
logic/baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_regs.sv
logic/uart_top.sv
sim/uart_props.sv
sim/uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= uart_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
